//--- design/ex_config.svh
//----------------------------------------
// fixed widths and flag bit positions
// of the execute stage; the datapath is
// 32-bit only and these do not change
//----------------------------------------
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

`define EX_DATA_W  32

// flag bits in the 32-bit flags word
`define EX_FLAG_CF 0
`define EX_FLAG_PF 2
`define EX_FLAG_AF 4
`define EX_FLAG_ZF 6
`define EX_FLAG_SF 7
`define EX_FLAG_DF 10
`define EX_FLAG_OF 11

`endif

//--- design/ex_pkg.sv
//----------------------------------------
// types shared by the execute stage
// micro-op kinds, alu operations and
// operand sizes; size code 3 is unused
// and treated as 32-bit by the datapath
//----------------------------------------
package ex_pkg;

	// micro-op kinds seen by EX
	typedef enum logic [2:0] {
		UOP_ALU         = 3'd0,
		UOP_PASS_A      = 3'd1,
		UOP_XCHG        = 3'd2,
		UOP_CMPXCHG     = 3'd3,
		UOP_CMPS_FIRST  = 3'd4,
		UOP_CMPS_SECOND = 3'd5,
		UOP_POP         = 3'd6
	} uop_e;

	// alu and shifter operations
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_ADC = 3'd1,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd3,
		ALU_OR  = 3'd4,
		ALU_XOR = 3'd5,
		ALU_SHL = 3'd6,
		ALU_SHR = 3'd7
	} alu_op_e;

	// operand size, also picks the pointer step
	typedef enum logic [1:0] {
		SIZE_8  = 2'd0,
		SIZE_16 = 2'd1,
		SIZE_32 = 2'd2
	} size_e;

endpackage

//--- design/ex_if.sv
//----------------------------------------
// operands and control of the micro-op
// in EX, driven by the operand select
// block and read by the other blocks
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

interface ex_operand_if;
	logic [`EX_DATA_W-1:0] a;
	// raw B operand, for pointers and routing
	logic [`EX_DATA_W-1:0] b;
	// B as seen by the alu
	logic [`EX_DATA_W-1:0] b_sel;
	logic [`EX_DATA_W-1:0] c;
	logic [`EX_DATA_W-1:0] count;
	logic [`EX_DATA_W-1:0] flags_in;
	ex_pkg::uop_e uop;
	ex_pkg::alu_op_e alu_op;
	ex_pkg::size_e size;
	// valid and not stalled
	logic accept;

	modport src (
		output a, b, b_sel, c, count, flags_in, uop, alu_op, size, accept
	);

	modport sink (
		input a, b, b_sel, c, count, flags_in, uop, alu_op, size, accept
	);
endinterface

//--- design/ex_operand_select.sv
//----------------------------------------
// operand selection for EX
// holds the first operand of a string
// compare until its second micro-op;
// the count always comes from C
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_operand_select (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  logic                  ex_valid,
	input  logic                  wb_stall,
	input  ex_pkg::uop_e          ex_uop,
	input  ex_pkg::alu_op_e       ex_alu_op,
	input  ex_pkg::size_e         ex_size,
	input  logic [`EX_DATA_W-1:0] ex_a,
	input  logic [`EX_DATA_W-1:0] ex_b,
	input  logic [`EX_DATA_W-1:0] ex_c,
	input  logic [`EX_DATA_W-1:0] ex_flags,
	ex_operand_if.src             ops
);

	logic                  accept;
	logic [`EX_DATA_W-1:0] cmps_tmp;

	assign accept = ex_valid & ~wb_stall;

	// first string operand, kept over stalls
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			cmps_tmp <= '0;
		end else if (accept && ex_uop == ex_pkg::UOP_CMPS_FIRST) begin
			cmps_tmp <= ex_a;
		end
	end

	assign ops.a        = ex_a;
	assign ops.b        = ex_b;
	// second compare uop subtracts the saved value
	assign ops.b_sel    = (ex_uop == ex_pkg::UOP_CMPS_SECOND) ? cmps_tmp : ex_b;
	assign ops.c        = ex_c;
	assign ops.count    = ex_c;
	assign ops.flags_in = ex_flags;
	assign ops.uop      = ex_uop;
	assign ops.alu_op   = ex_alu_op;
	assign ops.size     = ex_size;
	assign ops.accept   = accept;

endmodule

//--- design/ex_functional_unit.sv
//----------------------------------------
// alu, one-bit shifter and address math
// results are masked to the operand size;
// AF and OF read 0 after logic operations
// and AF reads 0 after shifts
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_functional_unit (
	ex_operand_if.sink            ops,
	output logic [`EX_DATA_W-1:0] alu_result,
	output logic [`EX_DATA_W-1:0] alu_flags,
	output logic [`EX_DATA_W-1:0] shift_result,
	output logic [`EX_DATA_W-1:0] shift_flags,
	output logic [`EX_DATA_W-1:0] count_step,
	output logic [`EX_DATA_W-1:0] pop_pointer,
	output logic [`EX_DATA_W-1:0] cmps_pointer
);

	function automatic logic [`EX_DATA_W-1:0] size_mask(input ex_pkg::size_e size);
		case (size)
			ex_pkg::SIZE_8:  size_mask = 32'h0000_00ff;
			ex_pkg::SIZE_16: size_mask = 32'h0000_ffff;
			default:         size_mask = 32'hffff_ffff;
		endcase
	endfunction

	// top bit of the sized value
	function automatic logic sign_bit(input logic [`EX_DATA_W:0] v, input ex_pkg::size_e size);
		case (size)
			ex_pkg::SIZE_8:  sign_bit = v[7];
			ex_pkg::SIZE_16: sign_bit = v[15];
			default:         sign_bit = v[31];
		endcase
	endfunction

	logic [`EX_DATA_W-1:0] mask;
	logic [`EX_DATA_W-1:0] a_m;
	logic [`EX_DATA_W-1:0] b_m;
	logic [`EX_DATA_W-1:0] step;
	logic [`EX_DATA_W:0]   wide;
	logic                  cin;
	logic                  cf;
	logic                  af;
	logic                  of;
	logic                  sh_cf;
	logic                  sh_of;
	ex_pkg::alu_op_e       op;

	assign mask = size_mask(ops.size);
	assign a_m  = ops.a & mask;
	assign b_m  = ops.b_sel & mask;
	assign cin  = ops.flags_in[`EX_FLAG_CF];

	//----------------------------------------
	// alu
	//----------------------------------------
	always_comb begin
		op = ops.alu_op;
		// compare uops always subtract
		if (ops.uop == ex_pkg::UOP_CMPXCHG || ops.uop == ex_pkg::UOP_CMPS_SECOND) begin
			op = ex_pkg::ALU_SUB;
		end
		wide = '0;
		cf = 1'b0;
		af = 1'b0;
		of = 1'b0;
		case (op)
			ex_pkg::ALU_ADD, ex_pkg::ALU_ADC: begin
				wide = {1'b0, a_m} + {1'b0, b_m} + {{`EX_DATA_W{1'b0}}, cin & (op == ex_pkg::ALU_ADC)};
				alu_result = wide[`EX_DATA_W-1:0] & mask;
				cf = sign_bit(wide >> 1, ops.size);
				af = a_m[4] ^ b_m[4] ^ alu_result[4];
				of = (sign_bit({1'b0, a_m}, ops.size) == sign_bit({1'b0, b_m}, ops.size)) &&
					(sign_bit({1'b0, alu_result}, ops.size) != sign_bit({1'b0, a_m}, ops.size));
			end
			ex_pkg::ALU_SUB: begin
				wide = {1'b0, a_m} - {1'b0, b_m};
				alu_result = wide[`EX_DATA_W-1:0] & mask;
				// a borrow sets every bit above the operand
				cf = sign_bit(wide >> 1, ops.size);
				af = a_m[4] ^ b_m[4] ^ alu_result[4];
				of = (sign_bit({1'b0, a_m}, ops.size) != sign_bit({1'b0, b_m}, ops.size)) &&
					(sign_bit({1'b0, alu_result}, ops.size) != sign_bit({1'b0, a_m}, ops.size));
			end
			ex_pkg::ALU_AND: alu_result = a_m & b_m;
			ex_pkg::ALU_OR:  alu_result = a_m | b_m;
			ex_pkg::ALU_XOR: alu_result = a_m ^ b_m;
			default:         alu_result = a_m;
		endcase
		alu_flags = ops.flags_in;
		alu_flags[`EX_FLAG_CF] = cf;
		alu_flags[`EX_FLAG_PF] = ~^alu_result[7:0];
		alu_flags[`EX_FLAG_AF] = af;
		alu_flags[`EX_FLAG_ZF] = (alu_result == '0);
		alu_flags[`EX_FLAG_SF] = sign_bit({1'b0, alu_result}, ops.size);
		alu_flags[`EX_FLAG_OF] = of;
	end

	//----------------------------------------
	// shifter, one bit per uop
	//----------------------------------------
	always_comb begin
		if (ops.alu_op == ex_pkg::ALU_SHR) begin
			shift_result = a_m >> 1;
			sh_cf = a_m[0];
			sh_of = sign_bit({1'b0, a_m}, ops.size);
		end else begin
			shift_result = (a_m << 1) & mask;
			sh_cf = sign_bit({1'b0, a_m}, ops.size);
			sh_of = sign_bit({1'b0, shift_result}, ops.size) ^ sh_cf;
		end
		shift_flags = ops.flags_in;
		shift_flags[`EX_FLAG_CF] = sh_cf;
		shift_flags[`EX_FLAG_PF] = ~^shift_result[7:0];
		shift_flags[`EX_FLAG_AF] = 1'b0;
		shift_flags[`EX_FLAG_ZF] = (shift_result == '0);
		shift_flags[`EX_FLAG_SF] = sign_bit({1'b0, shift_result}, ops.size);
		shift_flags[`EX_FLAG_OF] = sh_of;
	end

	// pointer step in bytes
	always_comb begin
		case (ops.size)
			ex_pkg::SIZE_8:  step = 32'd1;
			ex_pkg::SIZE_16: step = 32'd2;
			default:         step = 32'd4;
		endcase
	end

	// count stops at zero
	assign count_step   = (ops.count == '0) ? ops.count : ops.count - 1'b1;
	assign pop_pointer  = ops.c + step;
	assign cmps_pointer = ops.flags_in[`EX_FLAG_DF] ? ops.b - step : ops.b + step;

endmodule

//--- design/ex_writeback_control.sv
//----------------------------------------
// write enables and valid for WB
// CMPXCHG uses ZF of A minus B; REPNE
// with a zero count ends the loop and
// leaves nothing to write
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_writeback_control (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  logic                  ex_ld_gpr1,
	input  logic                  ex_ld_gpr2,
	input  logic                  ex_dcache_write,
	input  logic                  ex_repne,
	input  logic                  wb_stall,
	input  logic [`EX_DATA_W-1:0] alu_flags,
	ex_operand_if.sink            ops,
	output logic                  ex_ready,
	output logic                  wb_valid,
	output logic                  wb_ld_gpr1,
	output logic                  wb_ld_gpr2,
	output logic                  wb_dcache_write,
	output logic                  wb_repne_done
);

	logic zf;
	logic terminate;
	logic live;
	logic ld_gpr1;
	logic ld_gpr2;
	logic dcache_write;

	assign zf        = alu_flags[`EX_FLAG_ZF];
	assign terminate = ex_repne && (ops.count == '0);
	assign live      = ops.accept & ~terminate;

	// compare-and-exchange write decision
	always_comb begin
		ld_gpr1 = ex_ld_gpr1;
		ld_gpr2 = ex_ld_gpr2;
		dcache_write = ex_dcache_write;
		if (ops.uop == ex_pkg::UOP_CMPXCHG) begin
			ld_gpr1 = ex_ld_gpr1 & zf;
			ld_gpr2 = ~zf;
			dcache_write = ex_dcache_write & zf;
		end
	end

	assign ex_ready = ~wb_stall;

	//----------------------------------------
	// WB control latches
	//----------------------------------------
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			wb_ld_gpr1 <= 1'b0;
			wb_ld_gpr2 <= 1'b0;
			wb_dcache_write <= 1'b0;
			wb_repne_done <= 1'b0;
		end else if (!wb_stall) begin
			// idle cycles load a bubble
			wb_valid <= live;
			wb_ld_gpr1 <= live & ld_gpr1;
			wb_ld_gpr2 <= live & ld_gpr2;
			wb_dcache_write <= live & dcache_write;
			wb_repne_done <= ops.accept & terminate;
		end
	end

endmodule

//--- design/ex_result_select.sv
//----------------------------------------
// result and flag selection by micro-op
// the WB result latches load only on an
// accepted uop and hold otherwise
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_result_select (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  logic                  wb_stall,
	input  logic [`EX_DATA_W-1:0] alu_result,
	input  logic [`EX_DATA_W-1:0] alu_flags,
	input  logic [`EX_DATA_W-1:0] shift_result,
	input  logic [`EX_DATA_W-1:0] shift_flags,
	input  logic [`EX_DATA_W-1:0] count_step,
	input  logic [`EX_DATA_W-1:0] pop_pointer,
	input  logic [`EX_DATA_W-1:0] cmps_pointer,
	ex_operand_if.sink            ops,
	output logic [`EX_DATA_W-1:0] wb_result_a,
	output logic [`EX_DATA_W-1:0] wb_result_b,
	output logic [`EX_DATA_W-1:0] wb_result_c,
	output logic [`EX_DATA_W-1:0] wb_flags
);

	logic [`EX_DATA_W-1:0] res_a;
	logic [`EX_DATA_W-1:0] res_b;
	logic [`EX_DATA_W-1:0] res_c;
	logic [`EX_DATA_W-1:0] res_flags;
	logic                  is_shift;

	assign is_shift = (ops.alu_op == ex_pkg::ALU_SHL) || (ops.alu_op == ex_pkg::ALU_SHR);

	always_comb begin
		// pass-through unless the uop says otherwise
		res_a = ops.a;
		res_b = ops.b;
		res_c = ops.c;
		res_flags = ops.flags_in;
		case (ops.uop)
			ex_pkg::UOP_ALU: begin
				res_a = is_shift ? shift_result : alu_result;
				res_flags = is_shift ? shift_flags : alu_flags;
			end
			ex_pkg::UOP_XCHG: begin
				res_a = ops.b;
				res_b = ops.a;
			end
			ex_pkg::UOP_CMPXCHG: begin
				res_a = ops.c;
				res_b = ops.a;
				res_flags = alu_flags;
			end
			ex_pkg::UOP_CMPS_FIRST: begin
				res_a = cmps_pointer;
				res_c = count_step;
			end
			ex_pkg::UOP_CMPS_SECOND: begin
				res_a = cmps_pointer;
				res_c = count_step;
				res_flags = alu_flags;
			end
			ex_pkg::UOP_POP: res_c = pop_pointer;
			default: ;
		endcase
	end

	// WB result latches
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_result_a <= '0;
			wb_result_b <= '0;
			wb_result_c <= '0;
			wb_flags <= '0;
		end else if (!wb_stall && ops.accept) begin
			wb_result_a <= res_a;
			wb_result_b <= res_b;
			wb_result_c <= res_c;
			wb_flags <= res_flags;
		end
	end

endmodule

//--- design/ex_stage.sv
//----------------------------------------
// execute stage with its WB latch
// one uop per cycle, one cycle latency;
// ex_ready is simply not wb_stall
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_stage (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  logic                  ex_valid,
	input  logic                  wb_stall,
	input  ex_pkg::uop_e          ex_uop,
	input  ex_pkg::alu_op_e       ex_alu_op,
	input  ex_pkg::size_e         ex_size,
	input  logic                  ex_repne,
	input  logic                  ex_ld_gpr1,
	input  logic                  ex_ld_gpr2,
	input  logic                  ex_dcache_write,
	input  logic [`EX_DATA_W-1:0] ex_a,
	input  logic [`EX_DATA_W-1:0] ex_b,
	input  logic [`EX_DATA_W-1:0] ex_c,
	input  logic [`EX_DATA_W-1:0] ex_flags,
	output logic                  ex_ready,
	output logic                  wb_valid,
	output logic [`EX_DATA_W-1:0] wb_result_a,
	output logic [`EX_DATA_W-1:0] wb_result_b,
	output logic [`EX_DATA_W-1:0] wb_result_c,
	output logic [`EX_DATA_W-1:0] wb_flags,
	output logic                  wb_ld_gpr1,
	output logic                  wb_ld_gpr2,
	output logic                  wb_dcache_write,
	output logic                  wb_repne_done
);

	logic [`EX_DATA_W-1:0] alu_result;
	logic [`EX_DATA_W-1:0] alu_flags;
	logic [`EX_DATA_W-1:0] shift_result;
	logic [`EX_DATA_W-1:0] shift_flags;
	logic [`EX_DATA_W-1:0] count_step;
	logic [`EX_DATA_W-1:0] pop_pointer;
	logic [`EX_DATA_W-1:0] cmps_pointer;

	ex_operand_if ops_if ();

	ex_operand_select operand_select_i (
		.CLK(CLK), .arst_n(arst_n), .ex_valid(ex_valid), .wb_stall(wb_stall),
		.ex_uop(ex_uop), .ex_alu_op(ex_alu_op), .ex_size(ex_size),
		.ex_a(ex_a), .ex_b(ex_b), .ex_c(ex_c), .ex_flags(ex_flags), .ops(ops_if.src)
	);

	ex_functional_unit functional_unit_i (
		.ops(ops_if.sink), .alu_result(alu_result), .alu_flags(alu_flags),
		.shift_result(shift_result), .shift_flags(shift_flags), .count_step(count_step),
		.pop_pointer(pop_pointer), .cmps_pointer(cmps_pointer)
	);

	ex_writeback_control writeback_control_i (
		.CLK(CLK), .arst_n(arst_n), .ex_ld_gpr1(ex_ld_gpr1), .ex_ld_gpr2(ex_ld_gpr2),
		.ex_dcache_write(ex_dcache_write), .ex_repne(ex_repne), .wb_stall(wb_stall),
		.alu_flags(alu_flags), .ops(ops_if.sink), .ex_ready(ex_ready), .wb_valid(wb_valid),
		.wb_ld_gpr1(wb_ld_gpr1), .wb_ld_gpr2(wb_ld_gpr2),
		.wb_dcache_write(wb_dcache_write), .wb_repne_done(wb_repne_done)
	);

	ex_result_select result_select_i (
		.CLK(CLK), .arst_n(arst_n), .wb_stall(wb_stall), .alu_result(alu_result),
		.alu_flags(alu_flags), .shift_result(shift_result), .shift_flags(shift_flags),
		.count_step(count_step), .pop_pointer(pop_pointer), .cmps_pointer(cmps_pointer),
		.ops(ops_if.sink), .wb_result_a(wb_result_a), .wb_result_b(wb_result_b),
		.wb_result_c(wb_result_c), .wb_flags(wb_flags)
	);

endmodule

//--- verif/ex_assertions.sv
//----------------------------------------
// concurrent checks bound into ex_stage
// stall hold, reset values and the
// valid / repne-done exclusion
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_assertions (
	input logic                  CLK,
	input logic                  arst_n,
	input logic                  wb_stall,
	input logic                  ex_ready,
	input logic                  wb_valid,
	input logic                  wb_repne_done,
	input logic                  wb_ld_gpr1,
	input logic                  wb_ld_gpr2,
	input logic                  wb_dcache_write,
	input logic [`EX_DATA_W-1:0] wb_result_a,
	input logic [`EX_DATA_W-1:0] wb_result_b,
	input logic [`EX_DATA_W-1:0] wb_result_c,
	input logic [`EX_DATA_W-1:0] wb_flags
);

	valid_done_exclusive: assert property (@(posedge CLK) disable iff (!arst_n)
		!(wb_valid && wb_repne_done))
		else $error("wb_valid and wb_repne_done high together");

	// a stalled edge leaves every WB output alone
	stall_holds_wb: assert property (@(posedge CLK) disable iff (!arst_n)
		wb_stall |=> $stable(wb_result_a) && $stable(wb_result_b) &&
			$stable(wb_result_c) && $stable(wb_flags) && $stable(wb_valid) &&
			$stable(wb_ld_gpr1) && $stable(wb_ld_gpr2) &&
			$stable(wb_dcache_write) && $stable(wb_repne_done))
		else $error("WB outputs changed under stall");

	ready_follows_stall: assert property (@(posedge CLK) ex_ready == !wb_stall)
		else $error("ex_ready does not follow wb_stall");

	reset_clears_control: assert property (@(posedge CLK)
		!arst_n |-> !wb_valid && !wb_ld_gpr1 && !wb_ld_gpr2 &&
			!wb_dcache_write && !wb_repne_done)
		else $error("control output high in reset");

endmodule

//--- verif/ex_checker.sv
//----------------------------------------
// scoreboard for the WB outputs
// expects one cycle latency; results are
// compared only for valid micro-ops
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_checker (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  logic                  ex_valid,
	input  logic                  wb_stall,
	input  logic                  ex_ready,
	input  logic [`EX_DATA_W-1:0] exp_a,
	input  logic [`EX_DATA_W-1:0] exp_b,
	input  logic [`EX_DATA_W-1:0] exp_c,
	input  logic [`EX_DATA_W-1:0] exp_flags,
	input  logic [2:0]            exp_en,
	input  logic                  exp_valid,
	input  logic                  exp_done,
	input  logic                  wb_valid,
	input  logic [`EX_DATA_W-1:0] wb_result_a,
	input  logic [`EX_DATA_W-1:0] wb_result_b,
	input  logic [`EX_DATA_W-1:0] wb_result_c,
	input  logic [`EX_DATA_W-1:0] wb_flags,
	input  logic                  wb_ld_gpr1,
	input  logic                  wb_ld_gpr2,
	input  logic                  wb_dcache_write,
	input  logic                  wb_repne_done,
	output int                    value_errors,
	output int                    other_errors,
	output int                    pending
);

	// a, b, c, flags, enables, valid, done
	logic [4*`EX_DATA_W+4:0] expect_q[$];
	logic [4*`EX_DATA_W+4:0] e;
	logic                    updated;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("ERR %s got %h exp %h", name, got, want);
			value_errors++;
		end
	endtask

	initial begin
		value_errors = 0;
		other_errors = 0;
		pending = 0;
		updated = 1'b0;
	end

	always @(posedge CLK) begin
		if (!arst_n) begin
			updated = 1'b0;
			if (wb_valid || wb_ld_gpr1 || wb_ld_gpr2 || wb_dcache_write || wb_repne_done) begin
				$display("control output high while in reset");
				other_errors++;
			end
		end else begin
			compare("ex_ready", {31'd0, ex_ready}, {31'd0, ~wb_stall});
			// the last unstalled edge loaded the WB latches
			if (updated && (wb_valid || wb_repne_done)) begin
				if (expect_q.size() == 0) begin
					$display("WB output seen with no accepted micro-op");
					other_errors++;
				end else begin
					e = expect_q.pop_front();
					compare("wb_valid", {31'd0, wb_valid}, {31'd0, e[1]});
					compare("wb_repne_done", {31'd0, wb_repne_done}, {31'd0, e[0]});
					compare("wb_ld_gpr1", {31'd0, wb_ld_gpr1}, {31'd0, e[4]});
					compare("wb_ld_gpr2", {31'd0, wb_ld_gpr2}, {31'd0, e[3]});
					compare("wb_dcache_write", {31'd0, wb_dcache_write}, {31'd0, e[2]});
					if (e[1]) begin
						compare("wb_result_a", wb_result_a, e[132:101]);
						compare("wb_result_b", wb_result_b, e[100:69]);
						compare("wb_result_c", wb_result_c, e[68:37]);
						compare("wb_flags", wb_flags, e[36:5]);
					end
				end
			end else if (updated && expect_q.size() != 0) begin
				$display("accepted micro-op did not reach WB");
				other_errors++;
				void'(expect_q.pop_front());
			end
			if (ex_valid && !wb_stall) begin
				expect_q.push_back({exp_a, exp_b, exp_c, exp_flags, exp_en, exp_valid, exp_done});
			end
			updated = !wb_stall;
		end
		pending = expect_q.size();
	end

endmodule

//--- verif/ex_tb.sv
//----------------------------------------
// testbench for ex_stage
// runs from the project root so the
// vector file path resolves; random gaps
// of idle or stalled cycles between uops
//----------------------------------------
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_tb;

	logic                  CLK;
	logic                  arst_n;
	logic                  ex_valid;
	logic                  wb_stall;
	ex_pkg::uop_e          ex_uop;
	ex_pkg::alu_op_e       ex_alu_op;
	ex_pkg::size_e         ex_size;
	logic                  ex_repne;
	logic                  ex_ld_gpr1;
	logic                  ex_ld_gpr2;
	logic                  ex_dcache_write;
	logic [`EX_DATA_W-1:0] ex_a;
	logic [`EX_DATA_W-1:0] ex_b;
	logic [`EX_DATA_W-1:0] ex_c;
	logic [`EX_DATA_W-1:0] ex_flags;
	logic                  ex_ready;
	logic                  wb_valid;
	logic [`EX_DATA_W-1:0] wb_result_a;
	logic [`EX_DATA_W-1:0] wb_result_b;
	logic [`EX_DATA_W-1:0] wb_result_c;
	logic [`EX_DATA_W-1:0] wb_flags;
	logic                  wb_ld_gpr1;
	logic                  wb_ld_gpr2;
	logic                  wb_dcache_write;
	logic                  wb_repne_done;

	// expectation of the uop being driven
	logic [`EX_DATA_W-1:0] exp_a;
	logic [`EX_DATA_W-1:0] exp_b;
	logic [`EX_DATA_W-1:0] exp_c;
	logic [`EX_DATA_W-1:0] exp_flags;
	logic [2:0]            exp_en;
	logic                  exp_valid;
	logic                  exp_done;

	logic [31:0] vec [0:63][0:15];
	int          vec_count;
	logic [31:0] rng;
	int          value_errors;
	int          other_errors;
	int          pending;
	// file and timeout problems seen by the bench itself
	int          bench_errors;

	ex_stage ex_stage_i (.*);

	ex_checker checker_i (.*);

	bind ex_stage ex_assertions assertions_i (
		.CLK(CLK), .arst_n(arst_n), .wb_stall(wb_stall), .ex_ready(ex_ready),
		.wb_valid(wb_valid), .wb_repne_done(wb_repne_done), .wb_ld_gpr1(wb_ld_gpr1),
		.wb_ld_gpr2(wb_ld_gpr2), .wb_dcache_write(wb_dcache_write),
		.wb_result_a(wb_result_a), .wb_result_b(wb_result_b),
		.wb_result_c(wb_result_c), .wb_flags(wb_flags)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic end_with_failure(input string reason);
		$display("%s", reason);
		$display("value errors %0d, other errors %0d", value_errors,
			other_errors + bench_errors);
		$display("*** FAILED ***");
		$finish;
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [0:15];
		vec_count = 0;
		fd = $fopen("verif/ex_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/ex_vectors.txt");
			bench_errors++;
		end else begin
			while (!$feof(fd) && vec_count < 64) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
						f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
					if (n != 16) begin
						$display("malformed line in vector file");
						bench_errors++;
					end else begin
						for (int k = 0; k < 16; k++) begin
							vec[vec_count][k] = f[k];
						end
						vec_count++;
					end
				end
			end
			$fclose(fd);
			if (vec_count == 0) begin
				$display("vector file holds no vectors");
				bench_errors++;
			end
		end
	endtask

	task automatic apply_vector(input int i);
		ex_uop = ex_pkg::uop_e'(vec[i][0][2:0]);
		ex_alu_op = ex_pkg::alu_op_e'(vec[i][1][2:0]);
		ex_size = ex_pkg::size_e'(vec[i][2][1:0]);
		ex_repne = vec[i][3][0];
		{ex_ld_gpr1, ex_ld_gpr2, ex_dcache_write} = vec[i][4][2:0];
		ex_a = vec[i][5];
		ex_b = vec[i][6];
		ex_c = vec[i][7];
		ex_flags = vec[i][8];
		exp_a = vec[i][9];
		exp_b = vec[i][10];
		exp_c = vec[i][11];
		exp_flags = vec[i][12];
		exp_en = vec[i][13][2:0];
		exp_valid = vec[i][14][0];
		exp_done = vec[i][15][0];
	endtask

	// hold the uop until an edge accepts it
	task automatic wait_accept();
		int tries;
		tries = 0;
		do begin
			@(posedge CLK);
			tries++;
		end while (!ex_ready && tries < 8);
		if (!ex_ready) begin
			$display("timeout waiting for ex_ready");
			bench_errors++;
		end
		#1;
	endtask

	task automatic wait_drain();
		int tries;
		tries = 0;
		while (pending != 0 && tries < 10) begin
			@(posedge CLK);
			#1;
			tries++;
		end
		if (pending != 0) begin
			$display("timeout waiting for the last results");
			bench_errors++;
		end
	endtask

	initial begin
		int gap;
		logic stall_mode;
		arst_n = 1'b0;
		ex_valid = 1'b0;
		wb_stall = 1'b0;
		ex_uop = ex_pkg::UOP_ALU;
		ex_alu_op = ex_pkg::ALU_ADD;
		ex_size = ex_pkg::SIZE_32;
		ex_repne = 1'b0;
		ex_ld_gpr1 = 1'b0;
		ex_ld_gpr2 = 1'b0;
		ex_dcache_write = 1'b0;
		ex_a = '0;
		ex_b = '0;
		ex_c = '0;
		ex_flags = '0;
		bench_errors = 0;
		rng = 32'd69;
		load_vectors();
		repeat (3) @(posedge CLK);
		#1;
		arst_n = 1'b1;
		for (int i = 0; i < vec_count; i++) begin
			rng = xorshift(rng);
			gap = int'(rng % 4);
			stall_mode = rng[4];
			// second string compare always sees a stall first
			if (vec[i][0] == 32'd5) begin
				stall_mode = 1'b1;
				if (gap == 0) begin
					gap = 1;
				end
			end
			apply_vector(i);
			repeat (gap) begin
				ex_valid = stall_mode;
				wb_stall = stall_mode;
				// a first string uop offered under stall must not be saved
				if (vec[i][0] == 32'd5) begin
					ex_uop = ex_pkg::UOP_CMPS_FIRST;
					ex_a = ~vec[i][5];
				end
				@(posedge CLK);
				#1;
			end
			apply_vector(i);
			wb_stall = 1'b0;
			ex_valid = 1'b1;
			wait_accept();
		end
		ex_valid = 1'b0;
		wait_drain();
		@(posedge CLK);
		#1;
		$display("value errors %0d, other errors %0d", value_errors,
			other_errors + bench_errors);
		if (value_errors == 0 && other_errors == 0 && bench_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#100000;
		end_with_failure("simulation watchdog expired");
	end

endmodule

//--- verif/ex_vectors.txt
# uop alu size repne en(gpr1,gpr2,dcache) a b c flags
# exp: a b c flags en valid repne_done  (all hex)
0 0 2 0 4 7fffffff 00000001 11111111 00000002 80000000 00000001 11111111 00000896 4 1 0
0 1 0 0 4 000012ff 00000001 00000000 00000003 00000001 00000001 00000000 00000013 4 1 0
0 2 1 0 4 00000005 00000007 22222222 00000002 0000fffe 00000007 22222222 00000093 4 1 0
0 3 2 0 5 f0f0f0f0 0ff00ff0 00000000 00000002 00f000f0 0ff00ff0 00000000 00000006 5 1 0
0 4 0 0 4 00000080 00000001 00000000 00000403 00000081 00000001 00000000 00000486 4 1 0
0 5 1 0 4 1234abcd 0000abcd 00000000 00000002 00000000 0000abcd 00000000 00000046 4 1 0
0 6 0 0 4 000000c1 00000005 00000000 00000002 00000082 00000005 00000000 00000087 4 1 0
0 7 2 0 4 80000003 00000000 00000000 00000002 40000001 00000000 00000000 00000803 4 1 0
0 0 1 0 4 0000ffff 00000001 00000000 00000002 00000000 00000001 00000000 00000057 4 1 0
1 0 2 0 6 aaaaaaaa bbbbbbbb cccccccc 00000446 aaaaaaaa bbbbbbbb cccccccc 00000446 6 1 0
2 0 2 0 6 00000011 00000022 00000033 00000002 00000022 00000011 00000033 00000002 6 1 0
6 0 2 0 4 12345678 00000000 00001000 00000002 12345678 00000000 00001004 00000002 4 1 0
6 0 1 0 4 00005678 00000009 00001000 00000002 00005678 00000009 00001002 00000002 4 1 0
4 0 0 0 0 00000041 00002000 00000005 00000002 00002001 00002000 00000004 00000002 0 1 0
5 0 0 0 0 00000041 00003000 00000004 00000002 00003001 00003000 00000003 00000046 0 1 0
4 0 2 0 0 00000010 00004000 00000000 00000402 00003ffc 00004000 00000000 00000402 0 1 0
5 0 2 0 0 00000008 00005000 00000000 00000402 00004ffc 00005000 00000000 00000483 0 1 0
3 0 2 0 5 00000077 00000077 00000099 00000002 00000099 00000077 00000099 00000046 5 1 0
3 0 2 0 5 00000077 00000078 00000099 00000002 00000099 00000077 00000099 00000097 2 1 0
1 0 2 1 4 00000001 00000002 00000000 00000002 00000001 00000002 00000000 00000002 0 0 1
4 0 1 1 0 00000050 00006000 00000003 00000002 00006002 00006000 00000002 00000002 0 1 0

//--- compile.f
+incdir+design
design/ex_pkg.sv
design/ex_if.sv
design/ex_operand_select.sv
design/ex_functional_unit.sv
design/ex_writeback_control.sv
design/ex_result_select.sv
design/ex_stage.sv
verif/ex_assertions.sv
verif/ex_checker.sv
verif/ex_tb.sv

//--- run.sh
#!/bin/sh
# build and run the ex_stage testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module ex_tb \
	-o ex_sim > build.log 2>&1 \
	&& ./obj_dir/ex_sim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error, see build.log and sim.log"

grep -qF "*** PASSED ***" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
